//--- div_unit.f
+incdir+rtl
rtl/div_pkg.sv
rtl/div_step_if.sv
rtl/div_norm.sv
rtl/div_qsel.sv
rtl/div_iter.sv
rtl/div_fixup.sv
rtl/div_ctrl.sv
rtl/div_unit.sv
test/div_unit_tb.sv

//--- rtl/div_ctrl.sv
`include "div_settings.svh"

module div_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issue_i,
    input  div_pkg::div_info_t          info_i,
    input  div_pkg::exe_status_t        status_i,
    input  logic                        redirect_i,
    input  logic [`DIV_ROB_WIDTH-1:0]   redirect_idx_i,
    div_step_if.ctrl                    step,
    output logic                        ready_o,
    output div_pkg::div_info_t          info_o,
    output div_pkg::exe_status_t        status_o,
    output logic                        finish_o,
    output logic                        wakeup_o,
    output logic [`DIV_PREG_WIDTH-1:0]  wakeup_rd_o,
    output logic                        kill_o
);

    localparam int IDX_W = $clog2(`DIV_STEPS);
    localparam int CNT_W = IDX_W + 1;

    logic [CNT_W-1:0]       cnt;
    logic                   ready_q;
    logic                   finish_q;
    logic                   busy;
    logic                   accept;
    logic                   issue_killed;
    logic                   op_killed;
    div_pkg::div_info_t     info_q;
    div_pkg::exe_status_t   status_q;

    // **************************************************************************
    // redirect age checks
    // **************************************************************************
    assign issue_killed = redirect_i & div_pkg::rob_younger(status_i.rob_idx, redirect_idx_i);
    assign op_killed    = redirect_i & div_pkg::rob_younger(status_q.rob_idx, redirect_idx_i);

    assign busy   = cnt != '0;
    assign accept = issue_i & ready_q & ~issue_killed;

    assign step.load     = accept;
    assign step.step     = busy;
    assign step.step_idx = IDX_W'(cnt - 1'b1);
    assign step.kill     = busy & op_killed;

    // **************************************************************************
    // step counter and ready
    // **************************************************************************
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt      <= '0;
            ready_q  <= 1'b1;
            finish_q <= 1'b0;
            status_q <= '0;
        end else begin
            finish_q <= (cnt == CNT_W'(1)) & ~op_killed;
            if (accept) begin
                cnt      <= CNT_W'(`DIV_STEPS);
                ready_q  <= 1'b0;
                status_q <= status_i;
            end else if (step.kill) begin
                cnt     <= '0;
                ready_q <= 1'b1;
            end else begin
                if (busy) begin
                    cnt <= cnt - 1'b1;
                end
                if (finish_q) begin
                    ready_q <= 1'b1;    // free again with writeback
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            info_q <= info_i;
        end
    end

    assign ready_o     = ready_q;
    assign info_o      = info_q;
    assign status_o    = status_q;
    assign finish_o    = finish_q;
    assign wakeup_o    = finish_q & ~op_killed;    // one cycle ahead of wb
    assign wakeup_rd_o = status_q.rd;
    assign kill_o      = op_killed;

endmodule

//--- rtl/div_fixup.sv
`include "div_settings.svh"

module div_fixup (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        finish_i,
    input  logic                        kill_i,
    input  div_pkg::div_info_t          info_i,
    input  div_pkg::exe_status_t        status_i,
    input  logic [2*`DIV_XLEN:0]        pa_i,
    input  logic [`DIV_XLEN-1:0]        b_i,
    input  logic [`DIV_XLEN-1:0]        q_pos_i,
    input  logic [`DIV_XLEN-1:0]        q_neg_i,
    output logic                        wb_en_o,
    output logic                        wb_we_o,
    output logic [`DIV_PREG_WIDTH-1:0]  wb_rd_o,
    output logic [`DIV_ROB_WIDTH-1:0]   wb_rob_idx_o,
    output logic [`DIV_XLEN-1:0]        wb_data_o
);

    localparam int W     = `DIV_XLEN;
    localparam int LZC_W = $clog2(`DIV_XLEN);

    logic [2*W:0]   pa_fix;
    logic [W-1:0]   q_neg_fix;
    logic [W-1:0]   q_a;
    logic [W-1:0]   q_b;
    logic [W-1:0]   quo;
    logic [W-1:0]   rem_mag;
    logic [W-1:0]   rem;
    logic [W-1:0]   abs_src1;
    logic [W-1:0]   res;
    logic           wb_q;

    always_comb begin
        // negative final residual, add the divisor back
        if (pa_i[2*W]) begin
            pa_fix    = pa_i + {1'b0, b_i, {W{1'b0}}};
            q_neg_fix = q_neg_i + 1'b1;
        end else begin
            pa_fix    = pa_i;
            q_neg_fix = q_neg_i;
        end
        q_a      = info_i.neg_q ? q_neg_fix : q_pos_i;
        q_b      = info_i.neg_q ? q_pos_i : q_neg_fix;
        quo      = q_a - q_b;
        rem_mag  = pa_fix[2*W-1:W] >> info_i.lzc;
        rem      = info_i.neg_r ? -rem_mag : rem_mag;
        abs_src1 = (info_i.is_signed && info_i.src1[W-1]) ? -info_i.src1 : info_i.src1;
        // |divisor| of 1 needs a full 32 bit quotient, more than 16 digits hold
        if (info_i.lzc == LZC_W'(W - 1)) begin
            quo = info_i.neg_q ? -abs_src1 : abs_src1;
            rem = '0;
        end
        if (info_i.zero) begin
            quo = '1;
            rem = info_i.src1;
        end else if (info_i.ovf) begin
            quo = info_i.src1;
            rem = '0;
        end
        res = info_i.is_rem ? rem : quo;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wb_q <= 1'b0;
        end else begin
            wb_q <= finish_i & ~kill_i;
        end
    end

    always_ff @(posedge clk) begin
        if (finish_i) begin
            wb_data_o    <= res;
            wb_we_o      <= status_i.we;
            wb_rd_o      <= status_i.rd;
            wb_rob_idx_o <= status_i.rob_idx;
        end
    end

    assign wb_en_o = wb_q & ~kill_i;    // late redirect drops it

endmodule

//--- rtl/div_iter.sv
`include "div_settings.svh"

module div_iter (
    input  logic                    clk,
    input  logic                    rst,
    div_step_if.iter                step,
    input  logic [2*`DIV_XLEN:0]    pa_i,
    input  logic [`DIV_XLEN-1:0]    b_i,
    output logic [2*`DIV_XLEN:0]    pa_o,
    output logic [`DIV_XLEN-1:0]    b_o,
    output logic [`DIV_XLEN-1:0]    q_pos_o,
    output logic [`DIV_XLEN-1:0]    q_neg_o
);

    localparam int W = `DIV_XLEN;

    logic [2*W:0]       pa;
    logic [2*W:0]       pa_shift;
    logic [2*W:0]       pa_next;
    logic [2*W:0]       d1;
    logic [2*W:0]       d2;
    logic [W-1:0]       b;
    logic [W-1:0]       q_pos;
    logic [W-1:0]       q_neg;
    logic [W-1:0]       digit_w;
    logic [1:0]         mag;
    logic signed [2:0]  q;

    div_qsel u_qsel (
        .b_i (b[W-1 -: 4]),
        .p_i (pa[2*W -: 6]),
        .q_o (q)
    );

    always_comb begin
        pa_shift = pa << 2;
        d1       = {1'b0, b, {W{1'b0}}};
        d2       = {b, {(W + 1){1'b0}}};
        case (q)
            3'b110:  pa_next = pa_shift + d2;
            3'b111:  pa_next = pa_shift + d1;
            3'b001:  pa_next = pa_shift - d1;
            3'b010:  pa_next = pa_shift - d2;
            default: pa_next = pa_shift;
        endcase
        mag     = q[2] ? 2'(-q) : 2'(q);
        digit_w = W'(mag) << {step.step_idx, 1'b0};  // 4^idx
    end

    always_ff @(posedge clk) begin
        if (step.load) begin
            pa <= pa_i;
            b  <= b_i;
        end else if (step.step && !step.kill) begin
            pa <= pa_next;
        end
    end

    // digits split by sign, resolved in fixup
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            q_pos <= '0;
            q_neg <= '0;
        end else if (step.load || step.kill) begin
            q_pos <= '0;
            q_neg <= '0;
        end else if (step.step) begin
            if (q[2]) begin
                q_neg <= q_neg + digit_w;
            end else begin
                q_pos <= q_pos + digit_w;
            end
        end
    end

    assign pa_o    = pa;
    assign b_o     = b;
    assign q_pos_o = q_pos;
    assign q_neg_o = q_neg;

endmodule

//--- rtl/div_norm.sv
`include "div_settings.svh"

module div_norm (
    input  div_pkg::div_op_e        op_i,
    input  logic [`DIV_XLEN-1:0]    rs1_i,
    input  logic [`DIV_XLEN-1:0]    rs2_i,
    output div_pkg::div_info_t      info_o,
    output logic [2*`DIV_XLEN:0]    pa_o,
    output logic [`DIV_XLEN-1:0]    b_o
);

    localparam int W     = `DIV_XLEN;
    localparam int LZC_W = $clog2(`DIV_XLEN);

    logic               is_signed;
    logic               sign_a;
    logic               sign_b;
    logic [W-1:0]       abs_a;
    logic [W-1:0]       abs_b;
    logic [LZC_W-1:0]   lzc;

    assign is_signed = (op_i == div_pkg::DIV) || (op_i == div_pkg::REM);
    assign sign_a    = is_signed & rs1_i[W-1];
    assign sign_b    = is_signed & rs2_i[W-1];
    assign abs_a     = sign_a ? -rs1_i : rs1_i;
    assign abs_b     = sign_b ? -rs2_i : rs2_i;

    // leading zeros of |divisor|, highest set bit wins
    always_comb begin
        lzc = '0;
        for (int i = 0; i < W; i++) begin
            if (abs_b[i]) begin
                lzc = LZC_W'(W - 1 - i);
            end
        end
    end

    // divisor msb lands on bit W-1
    assign pa_o = {{(W + 1){1'b0}}, abs_a} << lzc;
    assign b_o  = abs_b << lzc;

    assign info_o.is_signed = is_signed;
    assign info_o.is_rem    = (op_i == div_pkg::REM) || (op_i == div_pkg::REMU);
    assign info_o.zero      = rs2_i == '0;
    assign info_o.ovf       = is_signed && (rs1_i == {1'b1, {(W - 1){1'b0}}}) &&
                              (rs2_i == '1);
    assign info_o.neg_q     = sign_a ^ sign_b;
    assign info_o.neg_r     = sign_a;
    assign info_o.lzc       = lzc;
    assign info_o.src1      = rs1_i;

endmodule

//--- rtl/div_pkg.sv
`include "div_settings.svh"

package div_pkg;

    typedef enum logic [1:0] {
        DIV  = 2'd0,
        DIVU = 2'd1,
        REM  = 2'd2,
        REMU = 2'd3
    } div_op_e;

    typedef struct packed {
        logic [`DIV_ROB_WIDTH-1:0]  rob_idx;
        logic [`DIV_PREG_WIDTH-1:0] rd;
        logic                       we;
    } exe_status_t;

    typedef struct packed {
        logic                           is_signed;
        logic                           is_rem;
        logic                           zero;       // divisor is zero
        logic                           ovf;        // min / -1
        logic                           neg_q;
        logic                           neg_r;      // follows dividend sign
        logic [$clog2(`DIV_XLEN)-1:0]   lzc;
        logic [`DIV_XLEN-1:0]           src1;
    } div_info_t;

    // true when idx_a is younger than idx_b
    function automatic logic rob_younger(input logic [`DIV_ROB_WIDTH-1:0] idx_a,
                                         input logic [`DIV_ROB_WIDTH-1:0] idx_b);
        logic same_wrap;
        same_wrap = idx_a[`DIV_ROB_WIDTH-1] == idx_b[`DIV_ROB_WIDTH-1];
        if (same_wrap) begin
            return idx_a[`DIV_ROB_WIDTH-2:0] > idx_b[`DIV_ROB_WIDTH-2:0];
        end
        return idx_a[`DIV_ROB_WIDTH-2:0] < idx_b[`DIV_ROB_WIDTH-2:0];
    endfunction

endpackage

//--- rtl/div_qsel.sv
// radix-4 digit select, p is the residual top 6 bits, b the divisor top 4
module div_qsel (
    input  logic [3:0]          b_i,
    input  logic signed [5:0]   p_i,
    output logic signed [2:0]   q_o
);

    logic signed [5:0] th_p2;   // lowest p giving +2
    logic signed [5:0] th_p1;
    logic signed [5:0] th_z;
    logic signed [5:0] th_n1;

    // **************************************************************************
    // thresholds per divisor prefix
    // **************************************************************************
    always_comb begin
        case (b_i)
            4'b1001: begin
                th_p2 = 6'sd7;
                th_p1 = 6'sd3;
                th_z  = -6'sd2;
                th_n1 = -6'sd7;
            end
            4'b1010: begin
                th_p2 = 6'sd8;
                th_p1 = 6'sd3;
                th_z  = -6'sd2;
                th_n1 = -6'sd8;
            end
            4'b1011: begin
                th_p2 = 6'sd9;
                th_p1 = 6'sd3;
                th_z  = -6'sd2;
                th_n1 = -6'sd8;
            end
            4'b1100: begin
                th_p2 = 6'sd10;
                th_p1 = 6'sd4;
                th_z  = -6'sd3;
                th_n1 = -6'sd9;
            end
            4'b1101: begin
                th_p2 = 6'sd10;
                th_p1 = 6'sd4;
                th_z  = -6'sd3;
                th_n1 = -6'sd10;
            end
            4'b1110: begin
                th_p2 = 6'sd11;
                th_p1 = 6'sd4;
                th_z  = -6'sd3;
                th_n1 = -6'sd10;
            end
            4'b1111: begin
                th_p2 = 6'sd12;
                th_p1 = 6'sd5;
                th_z  = -6'sd3;
                th_n1 = -6'sd11;
            end
            default: begin      // 1000, divisor is normalized
                th_p2 = 6'sd6;
                th_p1 = 6'sd2;
                th_z  = -6'sd2;
                th_n1 = -6'sd6;
            end
        endcase
    end

    always_comb begin
        if (p_i >= th_p2) begin
            q_o = 3'sd2;
        end else if (p_i >= th_p1) begin
            q_o = 3'sd1;
        end else if (p_i >= th_z) begin
            q_o = 3'sd0;
        end else if (p_i >= th_n1) begin
            q_o = -3'sd1;
        end else begin
            q_o = -3'sd2;
        end
    end

endmodule

//--- rtl/div_settings.svh
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// datapath width
`define DIV_XLEN        32

// reorder buffer index, top bit is the wrap bit
`define DIV_ROB_WIDTH   6

`define DIV_PREG_WIDTH  6

// two quotient bits retire per step
`define DIV_STEPS       (`DIV_XLEN / 2)

`endif

//--- rtl/div_step_if.sv
`include "div_settings.svh"

// iteration control from the controller to the recurrence
interface div_step_if;

    logic                           load;       // capture operands, clear quotient
    logic                           step;
    logic [$clog2(`DIV_STEPS)-1:0]  step_idx;   // digit position, counts down
    logic                           kill;

    modport ctrl (
        output load,
        output step,
        output step_idx,
        output kill
    );

    modport iter (
        input  load,
        input  step,
        input  step_idx,
        input  kill
    );

endinterface

//--- rtl/div_unit.sv
`include "div_settings.svh"

module div_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issue_i,
    input  div_pkg::div_op_e            op_i,
    input  logic [`DIV_XLEN-1:0]        rs1_i,
    input  logic [`DIV_XLEN-1:0]        rs2_i,
    input  logic [`DIV_ROB_WIDTH-1:0]   rob_idx_i,
    input  logic [`DIV_PREG_WIDTH-1:0]  rd_i,
    input  logic                        we_i,
    input  logic                        redirect_i,
    input  logic [`DIV_ROB_WIDTH-1:0]   redirect_idx_i,
    output logic                        ready_o,
    output logic                        wakeup_o,
    output logic [`DIV_PREG_WIDTH-1:0]  wakeup_rd_o,
    output logic                        wb_en_o,
    output logic                        wb_we_o,
    output logic [`DIV_PREG_WIDTH-1:0]  wb_rd_o,
    output logic [`DIV_ROB_WIDTH-1:0]   wb_rob_idx_o,
    output logic [`DIV_XLEN-1:0]        wb_data_o
);

    localparam int W = `DIV_XLEN;

    div_pkg::exe_status_t   status_in;
    div_pkg::exe_status_t   status_held;
    div_pkg::div_info_t     info_norm;
    div_pkg::div_info_t     info_held;
    logic [2*W:0]           pa_norm;
    logic [2*W:0]           pa_iter;
    logic [W-1:0]           b_norm;
    logic [W-1:0]           b_iter;
    logic [W-1:0]           q_pos;
    logic [W-1:0]           q_neg;
    logic                   finish;
    logic                   kill;

    div_step_if step_bus ();

    assign status_in.rob_idx = rob_idx_i;
    assign status_in.rd      = rd_i;
    assign status_in.we      = we_i;

    div_norm u_norm (
        .op_i   (op_i),
        .rs1_i  (rs1_i),
        .rs2_i  (rs2_i),
        .info_o (info_norm),
        .pa_o   (pa_norm),
        .b_o    (b_norm)
    );

    div_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .issue_i        (issue_i),
        .info_i         (info_norm),
        .status_i       (status_in),
        .redirect_i     (redirect_i),
        .redirect_idx_i (redirect_idx_i),
        .step           (step_bus.ctrl),
        .ready_o        (ready_o),
        .info_o         (info_held),
        .status_o       (status_held),
        .finish_o       (finish),
        .wakeup_o       (wakeup_o),
        .wakeup_rd_o    (wakeup_rd_o),
        .kill_o         (kill)
    );

    div_iter u_iter (
        .clk     (clk),
        .rst     (rst),
        .step    (step_bus.iter),
        .pa_i    (pa_norm),
        .b_i     (b_norm),
        .pa_o    (pa_iter),
        .b_o     (b_iter),
        .q_pos_o (q_pos),
        .q_neg_o (q_neg)
    );

    div_fixup u_fixup (
        .clk          (clk),
        .rst          (rst),
        .finish_i     (finish),
        .kill_i       (kill),
        .info_i       (info_held),
        .status_i     (status_held),
        .pa_i         (pa_iter),
        .b_i          (b_iter),
        .q_pos_i      (q_pos),
        .q_neg_i      (q_neg),
        .wb_en_o      (wb_en_o),
        .wb_we_o      (wb_we_o),
        .wb_rd_o      (wb_rd_o),
        .wb_rob_idx_o (wb_rob_idx_o),
        .wb_data_o    (wb_data_o)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f div_unit.f --top-module div_unit_tb \
    -Mdir obj_dir -o div_unit_sim \
    && ./obj_dir/div_unit_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -qx "ALL CHECKS PASSED" sim.log \
    && exit 0 \
    || exit 1

//--- test/div_unit_tb.sv
`include "div_settings.svh"

module div_unit_tb;

    localparam int W          = `DIV_XLEN;
    localparam int RW         = `DIV_ROB_WIDTH;
    localparam int PW         = `DIV_PREG_WIDTH;
    localparam int WB_AT      = `DIV_STEPS + 1;    // edges from accept to writeback
    localparam int LIMIT      = 40;                // cycles per wait
    localparam int SEL_READY  = 0;
    localparam int SEL_WAKEUP = 1;
    localparam int SEL_WB     = 2;
    localparam logic [W-1:0] MIN_VAL = {1'b1, {(W - 1){1'b0}}};

    logic               clk;
    logic               rst;
    logic               issue_i;
    div_pkg::div_op_e   op_i;
    logic [W-1:0]       rs1_i;
    logic [W-1:0]       rs2_i;
    logic [RW-1:0]      rob_idx_i;
    logic [PW-1:0]      rd_i;
    logic               we_i;
    logic               redirect_i;
    logic [RW-1:0]      redirect_idx_i;
    logic               ready_o;
    logic               wakeup_o;
    logic [PW-1:0]      wakeup_rd_o;
    logic               wb_en_o;
    logic               wb_we_o;
    logic [PW-1:0]      wb_rd_o;
    logic [RW-1:0]      wb_rob_idx_o;
    logic [W-1:0]       wb_data_o;

    int                 err_cnt;
    int                 timeout_cnt;
    logic [W-1:0]       exp_q[$];       // expected results in issue order

    // reference view of the operation in flight
    logic               m_active;
    logic               m_seen;
    int                 m_edges;
    logic [RW-1:0]      m_rob;
    logic [PW-1:0]      m_rd;
    logic               m_we;
    logic [W-1:0]       m_res;
    logic               m_kill;
    logic               m_accept;
    logic               exp_ready;
    logic               exp_wakeup;
    logic               exp_wb;

    div_unit u_dut (
        .clk            (clk),
        .rst            (rst),
        .issue_i        (issue_i),
        .op_i           (op_i),
        .rs1_i          (rs1_i),
        .rs2_i          (rs2_i),
        .rob_idx_i      (rob_idx_i),
        .rd_i           (rd_i),
        .we_i           (we_i),
        .redirect_i     (redirect_i),
        .redirect_idx_i (redirect_idx_i),
        .ready_o        (ready_o),
        .wakeup_o       (wakeup_o),
        .wakeup_rd_o    (wakeup_rd_o),
        .wb_en_o        (wb_en_o),
        .wb_we_o        (wb_we_o),
        .wb_rd_o        (wb_rd_o),
        .wb_rob_idx_o   (wb_rob_idx_o),
        .wb_data_o      (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // a younger than b, the wrap bit flips the order of the low bits
    function automatic logic is_younger(input logic [RW-1:0] a, input logic [RW-1:0] b);
        logic same_lap;
        same_lap = ~(a[RW-1] ^ b[RW-1]);
        return same_lap ? (a[RW-2:0] > b[RW-2:0]) : (a[RW-2:0] < b[RW-2:0]);
    endfunction

    task automatic log_failure(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic end_of_run();
        $display("value errors: %0d, timeouts: %0d", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    // ************************************************************************
    // reference model
    // ************************************************************************
    task automatic ref_result(input logic [1:0] op, input logic [W-1:0] a,
                              input logic [W-1:0] b, output logic [W-1:0] res);
        logic         sgn;
        logic [W-1:0] q;
        logic [W-1:0] r;
        sgn = (op == div_pkg::DIV) || (op == div_pkg::REM);
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (sgn && a == MIN_VAL && b == '1) begin
            q = a;
            r = '0;
        end else if (sgn) begin
            q = $signed(a) / $signed(b);    // truncates toward zero
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        res = (op == div_pkg::REM || op == div_pkg::REMU) ? r : q;
    endtask

    always_comb begin
        m_kill     = m_active && redirect_i && is_younger(m_rob, redirect_idx_i);
        exp_ready  = !m_active || (m_edges == WB_AT);
        exp_wakeup = m_active && (m_edges == WB_AT - 1) && !m_kill;
        exp_wb     = m_active && (m_edges == WB_AT) && !m_kill;
        m_accept   = issue_i && exp_ready && !(redirect_i && is_younger(rob_idx_i, redirect_idx_i));
    end

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            m_active <= 1'b0;
            m_seen   <= 1'b0;
            m_edges  <= 0;
        end else begin
            if (m_active && (m_kill || m_edges == WB_AT)) begin
                m_active <= 1'b0;
            end else if (m_active) begin
                m_edges <= m_edges + 1;
            end
            if (m_accept) begin
                m_active <= 1'b1;
                m_seen   <= 1'b1;
                m_edges  <= 0;
                m_rob    <= rob_idx_i;
                m_rd     <= rd_i;
                m_we     <= we_i;
                m_res    <= exp_q.pop_front();
            end
        end
    end

    // ************************************************************************
    // checks
    // ************************************************************************
    a_reset_idle: assert property (@(posedge clk) disable iff (!rst)
        !m_seen |-> (ready_o && !wb_en_o && !wakeup_o))
        else log_failure("unit not idle after reset");
    a_ready: assert property (@(posedge clk) disable iff (!rst) ready_o == exp_ready)
        else log_failure($sformatf("ready_o %b, expected %b", ready_o, exp_ready));
    a_wakeup: assert property (@(posedge clk) disable iff (!rst) wakeup_o == exp_wakeup)
        else log_failure($sformatf("wakeup_o %b, expected %b", wakeup_o, exp_wakeup));
    a_wb_en: assert property (@(posedge clk) disable iff (!rst) wb_en_o == exp_wb)
        else log_failure($sformatf("wb_en_o %b, expected %b", wb_en_o, exp_wb));
    a_wakeup_rd: assert property (@(posedge clk) disable iff (!rst)
        exp_wakeup |-> wakeup_rd_o == m_rd)
        else log_failure($sformatf("wakeup_rd_o %0d, expected %0d", wakeup_rd_o, m_rd));
    a_wb_data: assert property (@(posedge clk) disable iff (!rst)
        exp_wb |-> wb_data_o == m_res)
        else log_failure($sformatf("wb_data_o %h, expected %h", wb_data_o, m_res));
    a_wb_fields: assert property (@(posedge clk) disable iff (!rst)
        exp_wb |-> {wb_rd_o, wb_we_o, wb_rob_idx_o} == {m_rd, m_we, m_rob})
        else log_failure($sformatf("wb fields rd %0d we %b rob %0d, expected %0d %b %0d",
                                   wb_rd_o, wb_we_o, wb_rob_idx_o, m_rd, m_we, m_rob));

    // ************************************************************************
    // stimulus
    // ************************************************************************
    function automatic logic watched(input int sel);
        case (sel)
            SEL_READY:  return ready_o;
            SEL_WAKEUP: return wakeup_o;
            default:    return wb_en_o;
        endcase
    endfunction

    task automatic wait_high(input int sel, input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!watched(sel) && n < LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (!watched(sel)) begin
            $display("DUT stuck: %s did not go high within %0d cycles", name, LIMIT);
            timeout_cnt++;
            end_of_run();
        end
    endtask

    function automatic logic [W-1:0] pick_operand();
        case ($urandom_range(0, 7))
            0:       return '0;
            1:       return W'(1);
            2:       return '1;
            3:       return MIN_VAL;
            4:       return ~MIN_VAL;
            default: return $urandom;
        endcase
    endfunction

    // b2b issues into the writeback cycle of the op in flight
    task automatic issue_op(input logic [1:0] op, input logic [W-1:0] a, input logic [W-1:0] b,
                            input logic [RW-1:0] rob, input logic b2b);
        logic [W-1:0] res;
        if (b2b) begin
            wait_high(SEL_WAKEUP, "wakeup_o");
        end else begin
            wait_high(SEL_READY, "ready_o");
        end
        ref_result(op, a, b, res);
        @(posedge clk);
        issue_i   <= 1'b1;
        op_i      <= div_pkg::div_op_e'(op);
        rs1_i     <= a;
        rs2_i     <= b;
        rob_idx_i <= rob;
        rd_i      <= PW'($urandom);
        we_i      <= 1'($urandom);
        exp_q.push_back(res);
        @(posedge clk);
        issue_i <= 1'b0;
    endtask

    task automatic check_pair(input logic sgn, input logic [W-1:0] a, input logic [W-1:0] b);
        logic [W-1:0] q;
        logic [W-1:0] r;
        longint       sa;
        longint       sb;
        longint       sq;
        longint       sr;
        issue_op(sgn ? div_pkg::DIV : div_pkg::DIVU, a, b, RW'($urandom), 1'b0);
        wait_high(SEL_WB, "wb_en_o");
        q = wb_data_o;
        issue_op(sgn ? div_pkg::REM : div_pkg::REMU, a, b, RW'($urandom), 1'b0);
        wait_high(SEL_WB, "wb_en_o");
        r  = wb_data_o;
        sa = sgn ? longint'($signed(a)) : longint'(a);
        sb = sgn ? longint'($signed(b)) : longint'(b);
        sq = sgn ? longint'($signed(q)) : longint'(q);
        sr = sgn ? longint'($signed(r)) : longint'(r);
        if (b == '0) begin
            assert (q == '1 && r == a)
                else log_failure($sformatf("divide by zero gave q %h r %h", q, r));
        end else if (sgn && a == MIN_VAL && b == '1) begin
            assert (q == a && r == '0)
                else log_failure($sformatf("overflow gave q %h r %h", q, r));
        end else begin
            assert (sq * sb + sr == sa)
                else log_failure($sformatf("q*b+r != a for a %h b %h", a, b));
            assert ((sr == 0 || (sr < 0) == (sa < 0)) && (sr < 0 ? -sr : sr) < (sb < 0 ? -sb : sb))
                else log_failure($sformatf("remainder %h out of range for a %h b %h", r, a, b));
        end
    endtask

    task automatic flush_op(input logic [RW-1:0] rob, input logic [RW-1:0] redir, input int delay);
        issue_op(div_pkg::DIV, pick_operand(), pick_operand(), rob, 1'b0);
        repeat (delay) @(posedge clk);
        redirect_i     <= 1'b1;
        redirect_idx_i <= redir;
        @(posedge clk);
        redirect_i <= 1'b0;
        wait_high(SEL_READY, "ready_o");
    endtask

    // redirect in the issue cycle, only a surviving op comes back
    task automatic redirect_at_issue(input logic [RW-1:0] rob, input logic [RW-1:0] redir);
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [W-1:0] res;
        a = pick_operand();
        b = pick_operand();
        ref_result(div_pkg::REM, a, b, res);
        wait_high(SEL_READY, "ready_o");
        @(posedge clk);
        issue_i        <= 1'b1;
        op_i           <= div_pkg::REM;
        rs1_i          <= a;
        rs2_i          <= b;
        rob_idx_i      <= rob;
        rd_i           <= PW'($urandom);
        we_i           <= 1'b1;
        redirect_i     <= 1'b1;
        redirect_idx_i <= redir;
        if (!is_younger(rob, redir)) begin
            exp_q.push_back(res);
        end
        @(posedge clk);
        issue_i    <= 1'b0;
        redirect_i <= 1'b0;
        wait_high(SEL_READY, "ready_o");
    endtask

    initial begin
        void'($urandom(32'h561f8a4e));
        err_cnt        = 0;
        timeout_cnt    = 0;
        rst            <= 1'b0;
        issue_i        <= 1'b0;
        op_i           <= div_pkg::DIV;
        rs1_i          <= '0;
        rs2_i          <= '0;
        rob_idx_i      <= '0;
        rd_i           <= '0;
        we_i           <= 1'b0;
        redirect_i     <= 1'b0;
        redirect_idx_i <= '0;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);

        // corner operands first
        check_pair(1'b1, MIN_VAL, '1);
        check_pair(1'b0, MIN_VAL, '1);
        check_pair(1'b1, 32'd123, '0);
        check_pair(1'b0, '1, '0);
        check_pair(1'b1, -32'sd7, 32'd2);
        check_pair(1'b1, 32'd7, -32'sd2);
        check_pair(1'b1, MIN_VAL, 32'd1);
        check_pair(1'b1, ~MIN_VAL, '1);
        check_pair(1'b0, 32'd1, ~MIN_VAL);
        for (int i = 0; i < 60; i++) begin
            check_pair(1'($urandom), pick_operand(), pick_operand());
        end

        // stream of all four ops, some issued in the writeback cycle
        for (int i = 0; i < 80; i++) begin
            issue_op(2'($urandom), pick_operand(), pick_operand(), RW'($urandom),
                     i > 0 && $urandom_range(0, 2) == 0);
        end
        wait_high(SEL_READY, "ready_o");

        flush_op(6'b0_01010, 6'b0_00100, 3);    // older redirect, same lap
        flush_op(6'b0_01010, 6'b0_01100, 3);
        flush_op(6'b1_00010, 6'b0_11110, 8);    // older across the wrap
        flush_op(6'b1_00010, 6'b0_00001, 8);
        flush_op(6'b0_10000, 6'b0_00011, 16);   // finish cycle
        flush_op(6'b0_10000, 6'b0_00011, 17);   // writeback cycle
        for (int i = 0; i < 30; i++) begin
            flush_op(RW'($urandom), RW'($urandom), $urandom_range(0, 17));
        end

        redirect_at_issue(6'b0_01010, 6'b0_00100);  // dropped as it issues
        redirect_at_issue(6'b1_00001, 6'b0_11100);  // dropped across the wrap
        redirect_at_issue(6'b0_00100, 6'b0_01010);
        repeat (2) @(posedge clk);
        end_of_run();
    end

endmodule
